// ==== Makefile ====
# Verilator simulation of the motor controller register side

VERILATOR ?= verilator
TOP       ?= tb_motor_ctrl
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== axis/axis_regs.sv ====
//------------------------------
// per-axis command and feedback registers, chans 1..4
// commands come up at zero current after reset
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qla_cfg.svh"

module axis_regs (
    input  wire logic                                   sysclk,
    input  wire logic                                   reset,
    reg_bus_if.target                                   bus,
    input  wire qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] cur_fb,
    input  wire logic                                   cur_fb_valid,
    output qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0]      cur_cmd
);

    qla_bus_pkg::chan_t                     chan;
    qla_bus_pkg::offs_t                     offs;
    qla_axis_pkg::axis_t                    axis;
    logic                                   chan_ok;
    qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] fb_q;       // captured ADC samples
    qla_bus_pkg::word_t                     rd_word;

    //------------------------------
    // address decode
    //------------------------------
    assign chan    = bus.addr[`QLA_ADDR_W-1 -: 4];
    assign offs    = bus.addr[3:0];
    assign axis    = chan[1:0] - 2'd1;                  // chan 1 is axis 0
    assign chan_ok = (chan != `QLA_CHAN_BOARD) &&
                     (chan <= qla_bus_pkg::chan_t'(`QLA_NUM_AXES));

    // DAC command registers
    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                cur_cmd[i] <= `QLA_CUR_MID;
            end
        end else if (bus.wen_axis && chan_ok && offs == `QLA_OFF_DAC_CTRL) begin
            cur_cmd[axis] <= bus.wdata[`QLA_CUR_W-1:0];
        end
    end

    // feedback capture, all axes at once
    always_ff @(posedge sysclk) begin
        if (cur_fb_valid) begin
            fb_q <= cur_fb;
        end
    end

    //------------------------------
    // readback, value in 15..0
    //------------------------------
    always_comb begin
        rd_word = '0;
        if (chan_ok) begin
            case (offs)
                `QLA_OFF_ADC_DATA: rd_word[`QLA_CUR_W-1:0] = fb_q[axis];
                `QLA_OFF_DAC_CTRL: rd_word[`QLA_CUR_W-1:0] = cur_cmd[axis];
                default:           rd_word = '0;            // unused offsets
            endcase
        end
    end

    assign bus.rdata_axis = rd_word;

endmodule

`default_nettype wire

// ==== axis/safety_monitor.sv ====
//------------------------------
// over-current check, trips at QLA_SAFETY_COUNT bad samples in a row
// a trip stays latched until clear_disable
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qla_cfg.svh"

module safety_monitor (
    input  wire logic                                   sysclk,
    input  wire logic                                   reset,
    input  wire qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] cur_fb,
    input  wire logic                                   cur_fb_valid,
    input  wire qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] cur_cmd,
    input  wire logic [`QLA_NUM_AXES-1:0]               clear_disable,
    output logic [`QLA_NUM_AXES-1:0]                    safety_disable
);

    qla_axis_pkg::trip_cnt_t [`QLA_NUM_AXES-1:0]    trip_cnt;
    logic [`QLA_NUM_AXES-1:0]                       over;
    logic [`QLA_NUM_AXES-1:0]                       trip;

    // distance from the zero-current code
    function automatic qla_axis_pkg::cur_t cur_mag(input qla_axis_pkg::cur_t val);
        if (val >= `QLA_CUR_MID) begin
            cur_mag = val - `QLA_CUR_MID;
        end else begin
            cur_mag = `QLA_CUR_MID - val;
        end
    endfunction

    //------------------------------
    // per-axis compare
    //------------------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        qla_axis_pkg::cur_t     fb_mag;
        qla_axis_pkg::cur_t     cmd_mag;
        logic [`QLA_CUR_W+1:0]  limit;      // 2*cmd + margin, no overflow

        assign fb_mag  = cur_mag(cur_fb[i]);
        assign cmd_mag = cur_mag(cur_cmd[i]);
        assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, `QLA_SAFETY_MARGIN};
        assign over[i] = ({2'b00, fb_mag} > limit);
        // this sample is the last one needed
        assign trip[i] = cur_fb_valid && over[i] &&
                         (trip_cnt[i] >= `QLA_SAFETY_COUNT - 2'd1);
    end

    // counters and latched disables
    always_ff @(posedge sysclk) begin
        if (reset) begin
            trip_cnt       <= '0;
            safety_disable <= '0;
        end else begin
            for (int i = 0; i < `QLA_NUM_AXES; i++) begin
                if (cur_fb_valid) begin
                    if (!over[i]) begin
                        trip_cnt[i] <= '0;                  // run broken
                    end else if (trip_cnt[i] != `QLA_SAFETY_COUNT) begin
                        trip_cnt[i] <= trip_cnt[i] + 2'd1;  // saturates
                    end
                end
                if (clear_disable[i]) begin
                    safety_disable[i] <= 1'b0;              // clear wins
                end else if (trip[i]) begin
                    safety_disable[i] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== board/board_regs.sv ====
//------------------------------
// board status register at chan 0, offset 0
// amp_en is gated by power and the latched safety trips
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qla_cfg.svh"

module board_regs (
    input  wire logic                       sysclk,
    input  wire logic                       reset,
    reg_bus_if.target                       bus,
    input  wire logic [3:0]                 board_id,
    input  wire logic [`QLA_NUM_AXES-1:0]   safety_disable,
    output logic [`QLA_NUM_AXES-1:0]        clear_disable,
    output logic [`QLA_NUM_AXES-1:0]        amp_en
);

    qla_bus_pkg::offs_t         offs;
    logic                       status_sel;
    logic                       pwr_enable;
    logic [`QLA_NUM_AXES-1:0]   amp_enable;
    qla_bus_pkg::word_t         status_word;

    assign offs       = bus.addr[3:0];
    assign status_sel = (offs == `QLA_OFF_STATUS);

    //------------------------------
    // enables and clear pulses
    //------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwr_enable    <= 1'b0;
            amp_enable    <= '0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;                            // one-cycle pulse
            if (bus.wen_board && status_sel) begin
                amp_enable <= bus.wdata[`QLA_NUM_AXES-1:0];
                pwr_enable <= bus.wdata[8];
                // power bit clears all axes, amp bit only its own
                clear_disable <= {`QLA_NUM_AXES{bus.wdata[8]}} |
                                 bus.wdata[`QLA_NUM_AXES-1:0];
            end
        end
    end

    // status word layout
    always_comb begin
        status_word                       = '0;
        status_word[`QLA_NUM_AXES-1:0]    = amp_enable;       // 3..0
        status_word[4 +: `QLA_NUM_AXES]   = safety_disable;   // 7..4
        status_word[8]                    = pwr_enable;
        status_word[27:24]                = board_id;
    end

    assign bus.rdata_board = status_sel ? status_word : '0;  // other offsets read 0

    // amplifier drive
    assign amp_en = {`QLA_NUM_AXES{pwr_enable}} & amp_enable & ~safety_disable;

endmodule

`default_nettype wire

// ==== common/qla_axis_pkg.sv ====
//------------------------------
// per-axis types
// current codes are offset binary around QLA_CUR_MID
//------------------------------

`default_nettype none

`include "qla_cfg.svh"

package qla_axis_pkg;

    // one current sample or command
    typedef logic [`QLA_CUR_W-1:0] cur_t;

    // axis index, 0 maps to channel 1
    typedef logic [1:0] axis_t;

    // consecutive over-current count
    // wide enough to hold QLA_SAFETY_COUNT
    typedef logic [1:0] trip_cnt_t;

endpackage

`default_nettype wire

// ==== common/qla_bus_pkg.sv ====
//------------------------------
// types of the host register bus
//------------------------------

`default_nettype none

`include "qla_cfg.svh"

package qla_bus_pkg;

    // full register address, chan in upper nibble
    typedef logic [`QLA_ADDR_W-1:0] addr_t;

    // address fields
    typedef logic [3:0] chan_t;     // upper nibble
    typedef logic [3:0] offs_t;     // lower nibble

    // register data word
    typedef logic [`QLA_DATA_W-1:0] word_t;

    // host handshake states
    typedef enum logic [1:0] {
        ST_IDLE,        // waiting for req
        ST_ACCESS,      // strobe cycle, rdata settles
        ST_HOLD         // ack high until req drops
    } bridge_state_t;

endpackage

`default_nettype wire

// ==== common/qla_cfg.svh ====
//------------------------------
// widths, address map and safety limits of the register side
// sizes are given explicitly where a value meets a vector
//------------------------------

`ifndef QLA_CFG_SVH
`define QLA_CFG_SVH

// bus widths
`define QLA_DATA_W          32          // register word
`define QLA_ADDR_W          8           // chan nibble + offset nibble
`define QLA_CUR_W           16          // current code, offset binary
`define QLA_NUM_AXES        4

// address map
`define QLA_CHAN_BOARD      4'd0        // axes follow at channels 1..4
`define QLA_OFF_STATUS      4'd0        // board status
`define QLA_OFF_ADC_DATA    4'd0        // feedback, per axis
`define QLA_OFF_DAC_CTRL    4'd1        // command, per axis

// safety check
`define QLA_CUR_MID         16'h8000    // zero current
`define QLA_SAFETY_MARGIN   16'h0100    // magnitude allowance
`define QLA_SAFETY_COUNT    2'd3        // consecutive samples to trip

`endif

// ==== common/reg_bus_if.sv ====
//------------------------------
// internal register bus, one bridge and two targets
// read data is combinational from addr in each target
//------------------------------

`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;

    logic               wen_board;      // one-cycle write strobe, chan 0
    logic               wen_axis;       // one-cycle write strobe, chan 1..4
    qla_bus_pkg::addr_t addr;           // held for the whole access
    qla_bus_pkg::word_t wdata;
    qla_bus_pkg::word_t rdata_board;    // status word or 0
    qla_bus_pkg::word_t rdata_axis;     // current readback or 0

    // host side
    modport bridge (
        output wen_board, wen_axis, addr, wdata,
        input  rdata_board, rdata_axis
    );

    // register blocks, each uses only its own strobe and rdata
    modport target (
        input  wen_board, wen_axis, addr, wdata,
        output rdata_board, rdata_axis
    );

endinterface

`default_nettype wire

// ==== logic/host_bridge.sv ====
//------------------------------
// four-phase req/ack host port onto the register bus
// host must hold we, addr, wdata while req is high
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qla_cfg.svh"

module host_bridge (
    input  wire logic               sysclk,
    input  wire logic               reset,
    input  wire logic               req,
    input  wire logic               we,
    input  wire qla_bus_pkg::addr_t addr,
    input  wire qla_bus_pkg::word_t wdata,
    output logic                    ack,
    output qla_bus_pkg::word_t      rdata,
    reg_bus_if.bridge               bus
);

    qla_bus_pkg::bridge_state_t state;
    qla_bus_pkg::chan_t         req_chan;
    logic                       hit_board;      // decode of incoming addr
    logic                       hit_axis;
    logic                       hit_board_q;    // decode held for the access
    logic                       hit_axis_q;
    logic                       wen_board_q;
    logic                       wen_axis_q;
    qla_bus_pkg::addr_t         addr_q;
    qla_bus_pkg::word_t         wdata_q;
    qla_bus_pkg::word_t         rd_sel;

    //------------------------------
    // channel decode, done once per request
    //------------------------------
    assign req_chan  = addr[`QLA_ADDR_W-1 -: 4];
    assign hit_board = (req_chan == `QLA_CHAN_BOARD);
    assign hit_axis  = (req_chan != `QLA_CHAN_BOARD) &&
                       (req_chan <= qla_bus_pkg::chan_t'(`QLA_NUM_AXES));

    //------------------------------
    // handshake FSM
    //------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state       <= qla_bus_pkg::ST_IDLE;
            ack         <= 1'b0;
            hit_board_q <= 1'b0;
            hit_axis_q  <= 1'b0;
            wen_board_q <= 1'b0;
            wen_axis_q  <= 1'b0;
        end else begin
            wen_board_q <= 1'b0;    // strobes last one cycle
            wen_axis_q  <= 1'b0;
            case (state)
                qla_bus_pkg::ST_IDLE: begin
                    if (req) begin
                        state       <= qla_bus_pkg::ST_ACCESS;
                        hit_board_q <= hit_board;
                        hit_axis_q  <= hit_axis;
                        wen_board_q <= we & hit_board;  // bad chan writes nothing
                        wen_axis_q  <= we & hit_axis;
                    end
                end
                qla_bus_pkg::ST_ACCESS: begin
                    state <= qla_bus_pkg::ST_HOLD;
                    ack   <= 1'b1;                      // rdata latched on this edge
                end
                qla_bus_pkg::ST_HOLD: begin
                    if (!req) begin                     // host saw ack
                        state <= qla_bus_pkg::ST_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= qla_bus_pkg::ST_IDLE;
            endcase
        end
    end

    // read select, zero when neither target was hit
    assign rd_sel = hit_board_q ? bus.rdata_board :
                    hit_axis_q  ? bus.rdata_axis  : '0;

    // request and read data latches
    always_ff @(posedge sysclk) begin
        if (state == qla_bus_pkg::ST_IDLE && req) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == qla_bus_pkg::ST_ACCESS) begin
            rdata <= rd_sel;        // stable while ack is high
        end
    end

    assign bus.addr      = addr_q;
    assign bus.wdata     = wdata_q;
    assign bus.wen_board = wen_board_q;
    assign bus.wen_axis  = wen_axis_q;

endmodule

`default_nettype wire

// ==== logic/motor_ctrl_top.sv ====
//------------------------------
// register side of the four-axis controller
// single clock domain, DAC/ADC serial links live outside
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qla_cfg.svh"

module motor_ctrl_top (
    input  wire logic                                   sysclk,
    input  wire logic                                   reset,
    // host port
    input  wire logic                                   req,
    input  wire logic                                   we,
    input  wire qla_bus_pkg::addr_t                     addr,
    input  wire qla_bus_pkg::word_t                     wdata,
    output logic                                        ack,
    output qla_bus_pkg::word_t                          rdata,
    // board and axes
    input  wire logic [3:0]                             board_id,
    input  wire qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] cur_fb,
    input  wire logic                                   cur_fb_valid,
    output qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0]      cur_cmd,
    output logic [`QLA_NUM_AXES-1:0]                    amp_en
);

    //------------------------------
    // local wires
    //------------------------------
    reg_bus_if bus ();

    logic [`QLA_NUM_AXES-1:0] safety_disable;   // latched trips
    logic [`QLA_NUM_AXES-1:0] clear_disable;    // pulse from status write

    host_bridge u_host_bridge (
        .sysclk (sysclk),
        .reset  (reset),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .bus    (bus.bridge)
    );

    board_regs u_board_regs (
        .sysclk         (sysclk),
        .reset          (reset),
        .bus            (bus.target),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .clear_disable  (clear_disable),
        .amp_en         (amp_en)
    );

    axis_regs u_axis_regs (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus          (bus.target),
        .cur_fb       (cur_fb),
        .cur_fb_valid (cur_fb_valid),
        .cur_cmd      (cur_cmd)        // to DAC port and safety check
    );

    safety_monitor u_safety_monitor (
        .sysclk         (sysclk),
        .reset          (reset),
        .cur_fb         (cur_fb),
        .cur_fb_valid   (cur_fb_valid),
        .cur_cmd        (cur_cmd),
        .clear_disable  (clear_disable),
        .safety_disable (safety_disable)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/qla_bus_pkg.sv
common/qla_axis_pkg.sv
common/reg_bus_if.sv
logic/host_bridge.sv
board/board_regs.sv
axis/axis_regs.sv
axis/safety_monitor.sv
logic/motor_ctrl_top.sv
verif/tb_motor_ctrl.sv

// ==== verif/motor_stim.txt ====
// op addr data v0 v1 v2 v3 (hex), v = feedback or expected cur_cmd per axis
// op 1 write, 2 read+expect, 3 feedback, 4 amp_en expect, 5 test end, 6 cur_cmd expect, f end
1 11 abcd8400 0 0 0 0
1 21 00007c00 0 0 0 0
1 31 00008200 0 0 0 0
1 41 00008000 0 0 0 0
2 11 00008400 0 0 0 0
2 21 00007c00 0 0 0 0
2 31 00008200 0 0 0 0
2 41 00008000 0 0 0 0
6 00 00000000 8400 7c00 8200 8000
5 00 00000001 0 0 0 0
3 00 00000000 8100 7f00 8050 8010
2 10 00008100 0 0 0 0
2 20 00007f00 0 0 0 0
2 30 00008050 0 0 0 0
2 40 00008010 0 0 0 0
2 12 00000000 0 0 0 0
2 50 00000000 0 0 0 0
5 00 00000002 0 0 0 0
1 00 0000000f 0 0 0 0
4 00 00000000 0 0 0 0
1 00 00000105 0 0 0 0
4 00 00000005 0 0 0 0
2 00 0a000105 0 0 0 0
1 00 0000010f 0 0 0 0
4 00 0000000f 0 0 0 0
5 00 00000003 0 0 0 0
3 00 00000000 8100 7000 8050 8010
3 00 00000000 8100 7000 8050 8010
3 00 00000000 8100 7000 8050 8010
4 00 0000000d 0 0 0 0
2 00 0a00012f 0 0 0 0
2 20 00007000 0 0 0 0
5 00 00000004 0 0 0 0
3 00 00000000 8100 7f00 8800 8010
3 00 00000000 8100 7f00 8800 8010
3 00 00000000 8100 7f00 8050 8010
3 00 00000000 8100 7f00 8800 8010
3 00 00000000 8100 7f00 8800 8010
4 00 0000000d 0 0 0 0
2 00 0a00012f 0 0 0 0
5 00 00000005 0 0 0 0
1 00 00000002 0 0 0 0
2 00 0a000002 0 0 0 0
4 00 00000000 0 0 0 0
1 00 0000010f 0 0 0 0
2 00 0a00010f 0 0 0 0
4 00 0000000f 0 0 0 0
5 00 00000006 0 0 0 0
f 00 00000000 0 0 0 0

// ==== verif/tb_motor_ctrl.sv ====
//------------------------------
// testbench for motor_ctrl_top, stimulus from verif/motor_stim.txt
// run from the project root so the stimulus path resolves
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qla_cfg.svh"

module tb_motor_ctrl;

    localparam int REC_W   = 7;                 // words per stimulus line
    localparam int MAX_REC = 128;

    logic                                   sysclk;
    logic                                   reset;
    logic                                   req;
    logic                                   we;
    qla_bus_pkg::addr_t                     addr;
    qla_bus_pkg::word_t                     wdata;
    logic                                   ack;
    qla_bus_pkg::word_t                     rdata;
    logic [3:0]                             board_id;
    qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] cur_fb;
    logic                                   cur_fb_valid;
    qla_axis_pkg::cur_t [`QLA_NUM_AXES-1:0] cur_cmd;
    logic [`QLA_NUM_AXES-1:0]               amp_en;

    logic [31:0] stim [0:REC_W*MAX_REC-1];     // op addr data v0 v1 v2 v3
    int          num_rec;
    int          cycle_cnt;
    int          cycle_limit;
    int          err_cnt;
    int          test_err;                      // err_cnt when the test began
    int          test_cnt;
    int          fail_tests;

    motor_ctrl_top u_motor_ctrl_top (
        .sysclk       (sysclk),
        .reset        (reset),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .ack          (ack),
        .rdata        (rdata),
        .board_id     (board_id),
        .cur_fb       (cur_fb),
        .cur_fb_valid (cur_fb_valid),
        .cur_cmd      (cur_cmd),
        .amp_en       (amp_en)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;           // 20 ns period
    end

    // run limit, 40 cycles per stimulus line
    always @(posedge sysclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: no end of stimulus after %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %08h expected %08h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    //------------------------------
    // host port, four-phase handshake
    //------------------------------
    task automatic wait_ack(input logic level);
        while (ack !== level) begin
            @(posedge sysclk);
            #2;                                 // look between edges
        end
    endtask

    task automatic host_access(input logic wr, input qla_bus_pkg::addr_t a,
                               input qla_bus_pkg::word_t d, output qla_bus_pkg::word_t rd);
        @(posedge sysclk);
        #2;
        we    = wr;
        addr  = a;
        wdata = d;
        req   = 1'b1;
        wait_ack(1'b1);
        rd  = rdata;                            // valid while ack high
        req = 1'b0;
        wait_ack(1'b0);                         // next req only after ack low
    endtask

    // one valid cycle with four samples
    task automatic apply_feedback(input int base);
        @(posedge sysclk);
        #2;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            cur_fb[i] = stim[base + 3 + i][15:0];
        end
        cur_fb_valid = 1'b1;
        @(posedge sysclk);
        #2;
        cur_fb_valid = 1'b0;
    endtask

    task automatic check_cmd(input int base);
        @(posedge sysclk);
        #2;
        for (int i = 0; i < `QLA_NUM_AXES; i++) begin
            check_value(32'(cur_cmd[i]), stim[base + 3 + i], $sformatf("cur_cmd[%0d]", i));
        end
    endtask

    task automatic end_test(input int num);
        test_cnt++;
        if (err_cnt == test_err) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed, %0d errors", num, err_cnt - test_err);
            fail_tests++;
        end
        test_err = err_cnt;
    endtask

    //------------------------------
    // main sequence
    //------------------------------
    initial begin
        qla_bus_pkg::word_t rd;
        int                 base;
        req          = 1'b0;
        we           = 1'b0;
        addr         = '0;
        wdata        = '0;
        board_id     = 4'ha;
        cur_fb       = {`QLA_NUM_AXES{16'h8000}};     // zero current
        cur_fb_valid = 1'b0;
        reset        = 1'b1;
        cycle_cnt    = 0;
        err_cnt      = 0;
        test_err     = 0;
        test_cnt     = 0;
        fail_tests   = 0;
        num_rec      = 0;
        $readmemh("verif/motor_stim.txt", stim);
        while (num_rec < MAX_REC && stim[num_rec * REC_W] != 32'hf) begin
            num_rec++;                          // op f ends the list
        end
        cycle_limit = 40 * (num_rec + 1);
        repeat (2) @(posedge sysclk);
        #2;
        reset = 1'b0;

        for (int r = 0; r < num_rec; r++) begin
            base = r * REC_W;
            case (stim[base])
                32'h1: host_access(1'b1, stim[base + 1][7:0], stim[base + 2], rd);
                32'h2: begin
                    host_access(1'b0, stim[base + 1][7:0], '0, rd);
                    check_value(rd, stim[base + 2],
                                $sformatf("read addr %02h", stim[base + 1][7:0]));
                end
                32'h3: apply_feedback(base);
                32'h4: begin
                    @(posedge sysclk);
                    #2;
                    check_value(32'(amp_en), stim[base + 2], "amp_en");
                end
                32'h5: end_test(int'(stim[base + 2]));
                32'h6: check_cmd(base);
                default: begin
                    $display("stimulus line %0d has unknown op %0h", r, stim[base]);
                    err_cnt++;
                end
            endcase
        end

        $display("tests %0d, failed tests %0d, errors %0d", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0 && test_cnt > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
